//--- hw/wb_master_pkg.sv
/*
  Shared widths and enumerations for the Wishbone master.
  Assumes a 32-bit byte-addressed bus with four byte lanes.
  A line-fill burst defaults to four beats.
*/

package wb_master_pkg;

    // bus geometry, one byte lane per 8 data bits
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // beats in a cache line fill, the top level takes this as its default
    localparam int BURST_BEATS_DEF = 4;

    // sequencer states
    // st_burst covers every beat of a qword read except the last one
    typedef enum logic [1:0] {
        st_idle,
        st_burst,
        st_wait_ack
    } wb_state_t;

    // which cache port owns the access on the bus
    typedef enum logic [1:0] {
        src_none,
        src_icache,
        src_dcache_cached,
        src_dcache_uncached
    } req_src_t;

endpackage

//--- hw/wb_req_if.sv
/*
  Carries one selected request from the arbiter to the sequencer.
  Request fields stay stable while req_valid is high.
*/

`timescale 1ns/1ps

interface wb_req_if import wb_master_pkg::*;;

    // request side, driven by the arbiter
    logic              req_valid;
    req_src_t          req_src;
    logic              req_write;
    logic              req_qword;
    logic [ADDR_W-1:0] req_adr;
    logic [SEL_W-1:0]  req_sel;
    logic [DATA_W-1:0] req_dat;

    // completion side, driven by the sequencer
    // req_take and beat_ack are single-cycle pulses
    logic              req_take;
    logic              beat_ack;
    req_src_t          active_src;

    modport arb (
        output req_valid, req_src, req_write, req_qword, req_adr, req_sel, req_dat,
        input  req_take, beat_ack, active_src
    );

    modport seq (
        input  req_valid, req_src, req_write, req_qword, req_adr, req_sel, req_dat,
        output req_take, beat_ack, active_src
    );

endinterface

//--- hw/wb_request_arbiter.sv
/*
  Holds one pending request per cache and offers the data cache first.
  Assumes a cache sends no new strobe before the final ready of its last one.
  Ready outputs are combinational pulses that follow the slave acknowledge.
*/

`timescale 1ns/1ps

module wb_request_arbiter import wb_master_pkg::*;
(
    input  logic              i_clk,
    input  logic              quick_n_reset,

    input  logic              i_icache_req,
    input  logic              i_icache_qword,
    input  logic [ADDR_W-1:0] i_icache_address,

    input  logic              i_dcache_cached_req,
    input  logic              i_dcache_uncached_req,
    input  logic              i_dcache_qword,
    input  logic              i_dcache_write,
    input  logic [DATA_W-1:0] i_dcache_write_data,
    input  logic [SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [ADDR_W-1:0] i_dcache_address,

    output logic              o_icache_ready,
    output logic              o_dcache_cached_ready,
    output logic              o_dcache_uncached_ready,

    wb_req_if.arb             req
);

    // instruction cache slot
    logic              ic_pend;
    logic              ic_qword;
    logic [ADDR_W-1:0] ic_adr;

    // data cache slot, tagged cached or uncached
    logic              dc_pend;
    logic              dc_cached;
    logic              dc_write;
    logic              dc_qword;
    logic [ADDR_W-1:0] dc_adr;
    logic [DATA_W-1:0] dc_dat;
    logic [SEL_W-1:0]  dc_sel;

    logic              dc_strobe;

    // ====================
    // pending flags
    // ====================

    assign dc_strobe = i_dcache_cached_req || i_dcache_uncached_req;

    // the sequencer takes whichever slot is presented, and data cache comes first
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            ic_pend <= 1'b0;
            dc_pend <= 1'b0;
        end
        else
        begin
            if (i_icache_req)
                ic_pend <= 1'b1;
            else if (req.req_take && !dc_pend)
                ic_pend <= 1'b0;

            if (dc_strobe)
                dc_pend <= 1'b1;
            else if (req.req_take)
                dc_pend <= 1'b0;
        end
    end

    // request fields are captured with the strobe and held until the next one
    always_ff @(posedge i_clk)
    begin
        if (i_icache_req)
        begin
            ic_qword <= i_icache_qword;
            ic_adr   <= i_icache_address;
        end
        if (dc_strobe)
        begin
            dc_cached <= i_dcache_cached_req;
            dc_write  <= i_dcache_write;
            // writes are always single word
            dc_qword  <= i_dcache_qword && !i_dcache_write;
            dc_adr    <= i_dcache_address;
            dc_dat    <= i_dcache_write_data;
            dc_sel    <= i_dcache_byte_enable;
        end
    end

    // ====================
    // request selection
    // ====================

    always_comb
    begin
        req.req_valid = dc_pend || ic_pend;
        req.req_write = dc_pend && dc_write;
        req.req_qword = dc_pend ? dc_qword : ic_qword;
        req.req_adr   = dc_pend ? dc_adr : ic_adr;
        req.req_dat   = dc_dat;
        // reads always fetch the whole word
        req.req_sel   = (dc_pend && dc_write) ? dc_sel : '1;
        if (dc_pend)
            req.req_src = dc_cached ? src_dcache_cached : src_dcache_uncached;
        else if (ic_pend)
            req.req_src = src_icache;
        else
            req.req_src = src_none;
    end

    // each acknowledged beat becomes a ready on the port that owns the bus
    assign o_icache_ready          = req.beat_ack && (req.active_src == src_icache);
    assign o_dcache_cached_ready   = req.beat_ack && (req.active_src == src_dcache_cached);
    assign o_dcache_uncached_ready = req.beat_ack && (req.active_src == src_dcache_uncached);

endmodule

//--- hw/wb_bus_sequencer.sv
/*
  Drives Wishbone classic cycles for one request at a time.
  Qword reads run P_BURST_BEATS beats and wrap inside the line.
  A write's low address bits come from its byte-enable pattern.
*/

`timescale 1ns/1ps

module wb_bus_sequencer import wb_master_pkg::*;
#(
    parameter int P_BURST_BEATS = BURST_BEATS_DEF
)
(
    input  logic              i_clk,
    input  logic              quick_n_reset,

    wb_req_if.seq             req,

    output logic [ADDR_W-1:0] o_wb_adr,
    output logic [SEL_W-1:0]  o_wb_sel,
    output logic              o_wb_we,
    output logic [DATA_W-1:0] o_wb_dat,
    output logic              o_wb_cyc,
    output logic              o_wb_stb,
    input  logic              i_wb_ack
);

    // width of the beat counter and of the wrapping word index
    localparam int CNT_W = (P_BURST_BEATS > 1) ? $clog2(P_BURST_BEATS) : 1;

    wb_state_t  state;
    logic [CNT_W-1:0] beat_cnt;
    req_src_t   active_src_q;

    // byte offset of a write, picked from its lane pattern
    function automatic logic [1:0] be_offset(input logic [SEL_W-1:0] be);
        logic [1:0] off;
        case (be)
            4'b0001: off = 2'd0;
            4'b0010: off = 2'd1;
            4'b0100: off = 2'd2;
            4'b1000: off = 2'd3;
            // upper halfword
            4'b1100: off = 2'd2;
            default: off = 2'd0;
        endcase
        return off;
    endfunction

    // a request is accepted only from idle, so one idle cycle always separates accesses
    assign req.req_take   = (state == st_idle) && req.req_valid;
    assign req.beat_ack   = (state != st_idle) && i_wb_ack;
    assign req.active_src = active_src_q;

    // ====================
    // control state
    // ====================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state        <= st_idle;
            beat_cnt     <= '0;
            active_src_q <= src_none;
            o_wb_cyc     <= 1'b0;
            o_wb_stb     <= 1'b0;
            o_wb_we      <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (req.req_take)
                    begin
                        o_wb_cyc     <= 1'b1;
                        o_wb_stb     <= 1'b1;
                        o_wb_we      <= req.req_write;
                        active_src_q <= req.req_src;
                        beat_cnt     <= '0;
                        // a burst ends in st_wait_ack, which serves its last beat
                        if (req.req_qword && (P_BURST_BEATS > 1))
                            state <= st_burst;
                        else
                            state <= st_wait_ack;
                    end
                end

                st_burst:
                begin
                    if (i_wb_ack)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == CNT_W'(P_BURST_BEATS - 2))
                            state <= st_wait_ack;
                    end
                end

                st_wait_ack:
                begin
                    if (i_wb_ack)
                    begin
                        o_wb_cyc     <= 1'b0;
                        o_wb_stb     <= 1'b0;
                        o_wb_we      <= 1'b0;
                        active_src_q <= src_none;
                        state        <= st_idle;
                    end
                end

                default:
                    state <= st_idle;
            endcase
        end
    end

    // ====================
    // address and data
    // ====================

    always_ff @(posedge i_clk)
    begin
        if (req.req_take)
        begin
            o_wb_sel <= req.req_sel;
            o_wb_dat <= req.req_dat;
            // reads are word aligned, writes point at their first enabled byte
            if (req.req_write)
                o_wb_adr <= {req.req_adr[ADDR_W-1:2], be_offset(req.req_sel)};
            else
                o_wb_adr <= {req.req_adr[ADDR_W-1:2], 2'b00};
        end
        else if ((state == st_burst) && i_wb_ack)
        begin
            // only the word index inside the line moves, so the burst wraps
            o_wb_adr[2 +: CNT_W] <= o_wb_adr[2 +: CNT_W] + 1'b1;
        end
    end

endmodule

//--- hw/wb_master_top.sv
/*
  Wishbone master for the instruction and data caches.
  Read data for both caches is the bus word, valid only while ready is high.
  Data-cache requests win over instruction-cache requests.
*/

`timescale 1ns/1ps

module wb_master_top import wb_master_pkg::*;
#(
    parameter int P_BURST_BEATS = BURST_BEATS_DEF
)
(
    input  logic              i_clk,
    input  logic              quick_n_reset,

    // instruction cache
    input  logic              i_icache_req,
    input  logic              i_icache_qword,
    input  logic [ADDR_W-1:0] i_icache_address,
    output logic [DATA_W-1:0] o_icache_read_data,
    output logic              o_icache_ready,

    // data cache
    input  logic              i_dcache_cached_req,
    input  logic              i_dcache_uncached_req,
    input  logic              i_dcache_qword,
    input  logic              i_dcache_write,
    input  logic [DATA_W-1:0] i_dcache_write_data,
    input  logic [SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [ADDR_W-1:0] i_dcache_address,
    output logic [DATA_W-1:0] o_dcache_read_data,
    output logic              o_dcache_cached_ready,
    output logic              o_dcache_uncached_ready,

    // wishbone
    output logic [ADDR_W-1:0] o_wb_adr,
    output logic [SEL_W-1:0]  o_wb_sel,
    output logic              o_wb_we,
    output logic [DATA_W-1:0] o_wb_dat,
    output logic              o_wb_cyc,
    output logic              o_wb_stb,
    input  logic [DATA_W-1:0] i_wb_dat,
    input  logic              i_wb_ack
);

    wb_req_if u_req ();

    // both caches see the bus word directly, the ready pulses say who owns it
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

    wb_request_arbiter u_arbiter (
        .i_clk                   (i_clk),
        .quick_n_reset           (quick_n_reset),
        .i_icache_req            (i_icache_req),
        .i_icache_qword          (i_icache_qword),
        .i_icache_address        (i_icache_address),
        .i_dcache_cached_req     (i_dcache_cached_req),
        .i_dcache_uncached_req   (i_dcache_uncached_req),
        .i_dcache_qword          (i_dcache_qword),
        .i_dcache_write          (i_dcache_write),
        .i_dcache_write_data     (i_dcache_write_data),
        .i_dcache_byte_enable    (i_dcache_byte_enable),
        .i_dcache_address        (i_dcache_address),
        .o_icache_ready          (o_icache_ready),
        .o_dcache_cached_ready   (o_dcache_cached_ready),
        .o_dcache_uncached_ready (o_dcache_uncached_ready),
        .req                     (u_req.arb)
    );

    wb_bus_sequencer #(
        .P_BURST_BEATS (P_BURST_BEATS)
    ) u_sequencer (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .req           (u_req.seq),
        .o_wb_adr      (o_wb_adr),
        .o_wb_sel      (o_wb_sel),
        .o_wb_we       (o_wb_we),
        .o_wb_dat      (o_wb_dat),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .i_wb_ack      (i_wb_ack)
    );

endmodule

//--- tb/wb_master_properties.sv
/*
  Bus protocol and state checks, bound into every sequencer.
  Checks are off while reset is low.
*/

`timescale 1ns/1ps

module wb_master_properties import wb_master_pkg::*;
(
    input logic              i_clk,
    input logic              quick_n_reset,
    input logic              o_wb_stb,
    input logic              o_wb_cyc,
    input logic [ADDR_W-1:0] o_wb_adr,
    input logic              o_wb_we,
    input logic              i_wb_ack,
    input wb_state_t         state
);

    // number of assertion failures so far
    int unsigned fail_count = 0;

    // a strobe is only legal inside a cycle
    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_wb_stb |-> o_wb_cyc)
    else
    begin
        fail_count++;
        $error("stb high while cyc is low");
    end

    // a waiting beat keeps its address and direction
    a_hold_beat: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (o_wb_stb && !i_wb_ack) |=> ($stable(o_wb_adr) && $stable(o_wb_we)))
    else
    begin
        fail_count++;
        $error("address or we changed while a beat waited for ack");
    end

    // leaving idle goes to a burst or a single beat and opens a fresh strobe
    a_idle_exit: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        ((state != st_idle) && ($past(state) == st_idle)) |->
            ((state inside {st_burst, st_wait_ack}) && o_wb_stb && o_wb_cyc &&
             !$past(o_wb_stb)))
    else
    begin
        fail_count++;
        $error("sequencer left idle without starting a new bus cycle");
    end

endmodule

bind wb_bus_sequencer wb_master_properties u_props (
    .i_clk         (i_clk),
    .quick_n_reset (quick_n_reset),
    .o_wb_stb      (o_wb_stb),
    .o_wb_cyc      (o_wb_cyc),
    .o_wb_adr      (o_wb_adr),
    .o_wb_we       (o_wb_we),
    .i_wb_ack      (i_wb_ack),
    .state         (state)
);

//--- tb/tb_wb_master.sv
/*
  Testbench for the Wishbone master with a word-addressed slave model.
  The slave holds 64 words, so table addresses stay below 'h100.
  Read checks assume four-beat lines, which is the package default.
*/

`timescale 1ns/1ps

module tb_wb_master import wb_master_pkg::*;;

    localparam int BEATS          = BURST_BEATS_DEF;
    localparam int NUM_ROWS       = 18;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * BEATS * 8 + 100;

    localparam logic [1:0] SRC_IC  = 2'd0;
    localparam logic [1:0] SRC_DCC = 2'd1;
    localparam logic [1:0] SRC_DCU = 2'd2;

    // a row marked pair is strobed in the same cycle as the row after it
    typedef struct packed {
        logic [1:0]  src;
        logic        wr;
        logic        qw;
        logic        pair;
        logic [31:0] adr;
        logic [3:0]  be;
        logic [31:0] dat;
        logic [1:0]  off;
    } row_t;

    logic        i_clk;
    logic        quick_n_reset;
    logic        i_icache_req;
    logic        i_icache_qword;
    logic [31:0] i_icache_address;
    logic [31:0] o_icache_read_data;
    logic        o_icache_ready;
    logic        i_dcache_cached_req;
    logic        i_dcache_uncached_req;
    logic        i_dcache_qword;
    logic        i_dcache_write;
    logic [31:0] i_dcache_write_data;
    logic [3:0]  i_dcache_byte_enable;
    logic [31:0] i_dcache_address;
    logic [31:0] o_dcache_read_data;
    logic        o_dcache_cached_ready;
    logic        o_dcache_uncached_ready;
    logic [31:0] o_wb_adr;
    logic [3:0]  o_wb_sel;
    logic        o_wb_we;
    logic [31:0] o_wb_dat;
    logic        o_wb_cyc;
    logic        o_wb_stb;
    logic [31:0] i_wb_dat;
    logic        i_wb_ack;

    row_t        tbl [NUM_ROWS];
    logic [31:0] slave_mem [64];
    logic [31:0] shadow_mem [64];
    // every ready pulse is logged with its data and the cycle it came in
    logic [31:0] ic_data [$];
    logic [31:0] dcc_data [$];
    logic [31:0] dcu_data [$];
    int          ic_cyc [$];
    int          dc_cyc [$];
    logic [1:0]  wr_off;
    logic [3:0]  wr_sel;
    logic [31:0] wr_dat;
    logic [31:0] lfsr;
    int          base [3];
    int          cnt [3];
    int          dc_base;
    int          wait_left;
    int          cycles;
    int          value_errors;
    int          other_errors;
    logic        beat_open;

    wb_master_top #(.P_BURST_BEATS(BEATS)) dut (.*);

    // Fibonacci LFSR with taps 32 22 2 1 that shifts its new bit in at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // the fill pattern follows the whole byte address of the word
    function automatic logic [31:0] fill_word(input int w);
        logic [15:0] a;
        a = 16'(w * 4);
        return {~a, a ^ 16'h5a00};
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old,
                                                input logic [31:0] dat,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                res[8*b +: 8] = dat[8*b +: 8];
        return res;
    endfunction

    function automatic int beats_of(input row_t r);
        return (r.qw && !r.wr) ? BEATS : 1;
    endfunction

    // two LFSR steps give 0 to 3 wait cycles
    task automatic draw_wait(output int n);
        logic [1:0] b;
        lfsr = lfsr_step(lfsr);
        b[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        b[1] = lfsr[0];
        n = int'(b);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
        value_errors++;
    endtask

    task automatic check_idle(input string when_txt);
        if (o_wb_cyc || o_wb_stb || o_wb_we || o_icache_ready || o_dcache_cached_ready ||
            o_dcache_uncached_ready)
        begin
            $display("bus or ready outputs still active %s at t=%0t", when_txt, $time);
            other_errors++;
        end
    endtask

    task automatic start_row(input row_t r);
        if (r.src == SRC_IC)
        begin
            i_icache_req     = 1'b1;
            i_icache_qword   = r.qw;
            i_icache_address = r.adr;
        end
        else
        begin
            i_dcache_cached_req   = (r.src == SRC_DCC);
            i_dcache_uncached_req = (r.src == SRC_DCU);
            i_dcache_qword        = r.qw;
            i_dcache_write        = r.wr;
            i_dcache_write_data   = r.dat;
            i_dcache_byte_enable  = r.be;
            i_dcache_address      = r.adr;
        end
    endtask

    task automatic end_strobes;
        i_icache_req          = 1'b0;
        i_dcache_cached_req   = 1'b0;
        i_dcache_uncached_req = 1'b0;
    endtask

    // exact pulse counts per ready output catch misrouted or extra readies
    task automatic check_counts;
        if (ic_data.size() != base[0] + cnt[0])
            report_mismatch("o_icache_ready pulses", 32'(ic_data.size() - base[0]), 32'(cnt[0]));
        if (dcc_data.size() != base[1] + cnt[1])
            report_mismatch("o_dcache_cached_ready pulses", 32'(dcc_data.size() - base[1]),
                            32'(cnt[1]));
        if (dcu_data.size() != base[2] + cnt[2])
            report_mismatch("o_dcache_uncached_ready pulses", 32'(dcu_data.size() - base[2]),
                            32'(cnt[2]));
    endtask

    // reads compare each beat with the shadow word while writes check the bus and update it
    task automatic check_row(input row_t r);
        logic [31:0] got;
        logic [5:0]  idx;
        idx = r.adr[7:2];
        if (r.wr)
        begin
            if (wr_off !== r.off)
                report_mismatch("o_wb_adr[1:0]", 32'(wr_off), 32'(r.off));
            if (wr_sel !== r.be)
                report_mismatch("o_wb_sel", 32'(wr_sel), 32'(r.be));
            if (wr_dat !== r.dat)
                report_mismatch("o_wb_dat", wr_dat, r.dat);
            shadow_mem[idx] = merge_lanes(shadow_mem[idx], r.dat, r.be);
        end
        else
        begin
            for (int k = 0; k < beats_of(r); k++)
            begin
                case (r.src)
                    SRC_IC:  got = ic_data[base[0] + k];
                    SRC_DCC: got = dcc_data[base[1] + k];
                    default: got = dcu_data[base[2] + k];
                endcase
                // the beat index wraps inside the 16-byte line
                idx = {r.adr[7:4], r.adr[3:2] + 2'(k)};
                if (got !== shadow_mem[idx])
                    report_mismatch((r.src == SRC_IC) ? "o_icache_read_data"
                                                      : "o_dcache_read_data",
                                    got, shadow_mem[idx]);
            end
        end
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // ====================
    // slave model
    // ====================

    // ack comes 0 to 3 cycles after a beat starts and lasts one cycle
    initial
    begin
        i_wb_ack  = 1'b0;
        i_wb_dat  = '0;
        beat_open = 1'b0;
        wait_left = 0;
        lfsr      = 32'h4eef1957;
        for (int w = 0; w < 64; w++)
            slave_mem[w] = fill_word(w);
        forever
        begin
            @(posedge i_clk);
            #1;
            if (!quick_n_reset || i_wb_ack)
            begin
                i_wb_ack  = 1'b0;
                beat_open = 1'b0;
            end
            else if (o_wb_stb)
            begin
                if (!beat_open)
                begin
                    draw_wait(wait_left);
                    beat_open = 1'b1;
                end
                if (wait_left == 0)
                begin
                    i_wb_ack = 1'b1;
                    if (o_wb_we)
                        slave_mem[o_wb_adr[7:2]] = merge_lanes(slave_mem[o_wb_adr[7:2]],
                                                               o_wb_dat, o_wb_sel);
                    else
                        i_wb_dat = slave_mem[o_wb_adr[7:2]];
                end
                else
                    wait_left--;
            end
        end
    end

    // outputs settle after the rising edge and are logged on the falling edge
    always @(negedge i_clk)
    begin
        if (o_icache_ready)
        begin
            ic_data.push_back(o_icache_read_data);
            ic_cyc.push_back(cycles);
        end
        if (o_dcache_cached_ready)
        begin
            dcc_data.push_back(o_dcache_read_data);
            dc_cyc.push_back(cycles);
        end
        if (o_dcache_uncached_ready)
        begin
            dcu_data.push_back(o_dcache_read_data);
            dc_cyc.push_back(cycles);
        end
        if (o_wb_stb && o_wb_we && i_wb_ack)
        begin
            wr_off = o_wb_adr[1:0];
            wr_sel = o_wb_sel;
            wr_dat = o_wb_dat;
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout, the table did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    // ====================
    // stimulus table
    // ====================

    initial
    begin
        int i;
        int n;
        int total;
        quick_n_reset = 1'b0;
        i_icache_address = '0;
        i_icache_qword = 1'b0;
        i_dcache_qword = 1'b0;
        i_dcache_write = 1'b0;
        i_dcache_write_data = '0;
        i_dcache_byte_enable = '0;
        i_dcache_address = '0;
        end_strobes();
        value_errors = 0;
        other_errors = 0;
        for (int w = 0; w < 64; w++)
            shadow_mem[w] = fill_word(w);
        // src, write, qword, pair, address, byte enables, data, write offset
        tbl[0]  = '{SRC_IC,  1'b0, 1'b0, 1'b0, 32'h042, 4'hf, 32'h0, 2'd0};
        tbl[1]  = '{SRC_IC,  1'b0, 1'b1, 1'b0, 32'h048, 4'hf, 32'h0, 2'd0};
        tbl[2]  = '{SRC_DCC, 1'b1, 1'b0, 1'b0, 32'h080, 4'h1, 32'h11223344, 2'd0};
        tbl[3]  = '{SRC_DCU, 1'b1, 1'b0, 1'b0, 32'h084, 4'h2, 32'h55667788, 2'd1};
        tbl[4]  = '{SRC_DCC, 1'b1, 1'b0, 1'b0, 32'h088, 4'h4, 32'h99aabbcc, 2'd2};
        tbl[5]  = '{SRC_DCU, 1'b1, 1'b0, 1'b0, 32'h08c, 4'h8, 32'hddeeff00, 2'd3};
        tbl[6]  = '{SRC_DCC, 1'b1, 1'b0, 1'b0, 32'h090, 4'hc, 32'h13579bdf, 2'd2};
        tbl[7]  = '{SRC_DCU, 1'b1, 1'b0, 1'b0, 32'h094, 4'h3, 32'h2468ace0, 2'd0};
        tbl[8]  = '{SRC_DCC, 1'b1, 1'b0, 1'b0, 32'h098, 4'hf, 32'hcafef00d, 2'd0};
        tbl[9]  = '{SRC_DCC, 1'b0, 1'b0, 1'b0, 32'h080, 4'hf, 32'h0, 2'd0};
        tbl[10] = '{SRC_DCU, 1'b0, 1'b0, 1'b0, 32'h094, 4'hf, 32'h0, 2'd0};
        tbl[11] = '{SRC_DCC, 1'b0, 1'b1, 1'b0, 32'h08c, 4'hf, 32'h0, 2'd0};
        tbl[12] = '{SRC_DCU, 1'b0, 1'b1, 1'b0, 32'h094, 4'hf, 32'h0, 2'd0};
        tbl[13] = '{SRC_DCC, 1'b0, 1'b1, 1'b1, 32'h0a4, 4'hf, 32'h0, 2'd0};
        tbl[14] = '{SRC_IC,  1'b0, 1'b1, 1'b0, 32'h0c8, 4'hf, 32'h0, 2'd0};
        tbl[15] = '{SRC_DCU, 1'b1, 1'b0, 1'b1, 32'h0c0, 4'hf, 32'h0badcafe, 2'd0};
        tbl[16] = '{SRC_IC,  1'b0, 1'b0, 1'b0, 32'h0c0, 4'hf, 32'h0, 2'd0};
        tbl[17] = '{SRC_IC,  1'b0, 1'b1, 1'b0, 32'h0fd, 4'hf, 32'h0, 2'd0};

        repeat (2) @(posedge i_clk);
        #1;
        quick_n_reset = 1'b1;
        @(negedge i_clk);
        check_idle("after reset");
        @(posedge i_clk);
        #1;

        i = 0;
        while (i < NUM_ROWS)
        begin
            n = tbl[i].pair ? 2 : 1;
            base[0] = ic_data.size();
            base[1] = dcc_data.size();
            base[2] = dcu_data.size();
            dc_base = dc_cyc.size();
            cnt = '{0, 0, 0};
            for (int g = 0; g < n; g++)
            begin
                cnt[tbl[i + g].src] += beats_of(tbl[i + g]);
                start_row(tbl[i + g]);
            end
            @(posedge i_clk);
            #1;
            end_strobes();
            while ((ic_data.size() < base[0] + cnt[0]) ||
                   (dcc_data.size() < base[1] + cnt[1]) ||
                   (dcu_data.size() < base[2] + cnt[2]))
                @(posedge i_clk);
            // a few more cycles expose any extra ready pulse
            repeat (3) @(posedge i_clk);
            #1;
            check_counts();
            for (int g = 0; g < n; g++)
                check_row(tbl[i + g]);
            if ((n == 2) && (ic_cyc.size() > base[0]) && (dc_cyc.size() > dc_base))
            begin
                if (dc_cyc[dc_base] >= ic_cyc[base[0]])
                begin
                    $display("instruction cache was served before data cache at t=%0t", $time);
                    other_errors++;
                end
            end
            i = i + n;
        end

        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        check_idle("after the table");
        total = value_errors + other_errors + int'(dut.u_sequencer.u_props.fail_count);
        $display("errors: value=%0d other=%0d assertion=%0d", value_errors, other_errors,
                 dut.u_sequencer.u_props.fail_count);
        if (total == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- filelist.f
hw/wb_master_pkg.sv
hw/wb_req_if.sv
hw/wb_request_arbiter.sv
hw/wb_bus_sequencer.sv
hw/wb_master_top.sv
tb/wb_master_properties.sv
tb/tb_wb_master.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_wb_master -f filelist.f
	out=$$(./obj_dir/Vtb_wb_master +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
